/* source/uart_pkg.sv */
package uart_pkg;

    // 8N1 framing
    localparam int DATA_BITS = 8;

    typedef logic [DATA_BITS-1:0] byte_t;

    // ticks per bit, and start edge to mid start bit
    localparam int OVERSAMPLE = 16;
    localparam int HALF_BIT   = OVERSAMPLE / 2;

    localparam int CLK_HZ = 100_000_000;
    localparam int BAUD   = 9600;

    // 651 clocks per oversampling tick
    localparam int TICK_DIV = CLK_HZ / (BAUD * OVERSAMPLE);

    // shared by receiver and transmitter
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } frame_state_e;

endpackage

/* source/cmd_pkg.sv */
package cmd_pkg;

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_RIGHT,
        CMD_LEFT,
        CMD_UP,
        CMD_DOWN,
        CMD_MODE
    } cmd_e;

    // occupancy of the one-entry echo register
    typedef enum logic {
        EMPTY,
        FULL
    } echo_state_e;

    // ascii r, l, u, d, s
    localparam uart_pkg::byte_t ASC_RIGHT = 8'h72;
    localparam uart_pkg::byte_t ASC_LEFT  = 8'h6c;
    localparam uart_pkg::byte_t ASC_UP    = 8'h75;
    localparam uart_pkg::byte_t ASC_DOWN  = 8'h64;
    localparam uart_pkg::byte_t ASC_MODE  = 8'h73;

endpackage

/* source/baud_gen.sv */
`timescale 1ns/10ps

module baud_gen (
    input  logic clk,
    input  logic rst,
    output logic o_tick
);

    logic [$clog2(uart_pkg::TICK_DIV)-1:0] cnt;

    // one clock of tick at the end of every count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (int'(cnt) == uart_pkg::TICK_DIV - 1) begin
            cnt    <= '0;
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

/* source/uart_receiver.sv */
`timescale 1ns/10ps

module uart_receiver (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_tick,
    input  logic            i_rx,
    output uart_pkg::byte_t o_rx_data,
    output logic            o_rx_valid,
    input  logic            i_rx_ready
);

    uart_pkg::frame_state_e                  state;
    logic [$clog2(uart_pkg::OVERSAMPLE)-1:0] tick_cnt;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0]  bit_cnt;
    uart_pkg::byte_t                         shift_q;
    logic                                    bit_end;
    logic                                    frame_done;

    // mid-bit sample point of data and stop bits
    assign bit_end    = i_tick && (int'(tick_cnt) == uart_pkg::OVERSAMPLE - 1);
    assign frame_done = bit_end && (state == uart_pkg::STOP);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_pkg::IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (i_tick) begin
            case (state)
                uart_pkg::IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!i_rx) begin
                        state <= uart_pkg::START;
                    end
                end
                uart_pkg::START: begin
                    if (int'(tick_cnt) == uart_pkg::HALF_BIT - 1) begin
                        tick_cnt <= '0;
                        // line back high at mid-bit means a glitch
                        state    <= i_rx ? uart_pkg::IDLE : uart_pkg::DATA;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (int'(bit_cnt) == uart_pkg::DATA_BITS - 1) begin
                            state <= uart_pkg::STOP;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::STOP: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (frame_done) begin
                        state <= uart_pkg::IDLE;
                    end
                end
                default: state <= uart_pkg::IDLE;
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (bit_end && state == uart_pkg::DATA) begin
            shift_q <= {i_rx, shift_q[uart_pkg::DATA_BITS-1:1]};
        end
        if (frame_done) begin
            o_rx_data <= shift_q;
        end
    end

    // a new frame overwrites an unaccepted byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_rx_valid <= 1'b0;
        end else if (frame_done) begin
            o_rx_valid <= 1'b1;
        end else if (i_rx_ready) begin
            o_rx_valid <= 1'b0;
        end
    end

endmodule

/* source/uart_transmitter.sv */
`timescale 1ns/10ps

module uart_transmitter (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_tick,
    input  uart_pkg::byte_t i_tx_data,
    input  logic            i_tx_valid,
    output logic            o_tx_ready,
    output logic            o_tx
);

    uart_pkg::frame_state_e                  state;
    logic [$clog2(uart_pkg::OVERSAMPLE)-1:0] tick_cnt;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0]  bit_cnt;
    uart_pkg::byte_t                         shift_q;
    logic                                    accept;
    logic                                    bit_end;
    logic                                    load_bit;

    assign accept  = i_tx_valid && o_tx_ready;
    assign bit_end = i_tick && (int'(tick_cnt) == uart_pkg::OVERSAMPLE - 1);
    // next data bit goes out after start and after every data bit but the last
    assign load_bit = bit_end && ((state == uart_pkg::START) ||
                      (state == uart_pkg::DATA &&
                       int'(bit_cnt) != uart_pkg::DATA_BITS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= uart_pkg::IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            o_tx_ready <= 1'b0;
            o_tx       <= 1'b1;
        end else begin
            case (state)
                uart_pkg::IDLE: begin
                    tick_cnt   <= '0;
                    bit_cnt    <= '0;
                    o_tx_ready <= 1'b1;
                    if (accept) begin
                        state      <= uart_pkg::START;
                        o_tx_ready <= 1'b0;
                        o_tx       <= 1'b0;
                    end
                end
                uart_pkg::START, uart_pkg::DATA: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (load_bit) begin
                        o_tx <= shift_q[0];
                    end
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (state == uart_pkg::START) begin
                            state <= uart_pkg::DATA;
                        end else if (load_bit) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end else begin
                            state <= uart_pkg::STOP;
                            o_tx  <= 1'b1;
                        end
                    end
                end
                uart_pkg::STOP: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_end) begin
                        state      <= uart_pkg::IDLE;
                        o_tx_ready <= 1'b1;
                    end
                end
                default: state <= uart_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= i_tx_data;
        end else if (load_bit) begin
            shift_q <= {1'b0, shift_q[uart_pkg::DATA_BITS-1:1]};
        end
    end

endmodule

/* source/cmd_ctrl.sv */
`timescale 1ns/10ps

module cmd_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t i_rx_data,
    input  logic            i_rx_valid,
    output logic            o_rx_ready,
    output uart_pkg::byte_t o_tx_data,
    output logic            o_tx_valid,
    input  logic            i_tx_ready,
    input  logic            i_btn_right,
    input  logic            i_btn_left,
    input  logic            i_btn_up,
    input  logic            i_btn_down,
    output logic            o_right,
    output logic            o_left,
    output logic            o_up,
    output logic            o_down,
    output logic            o_mode
);

    cmd_pkg::echo_state_e state;
    cmd_pkg::cmd_e        cmd;
    logic                 rx_fire;
    logic                 req_right;
    logic                 req_left;
    logic                 req_up;
    logic                 req_down;

    assign o_rx_ready = (state == cmd_pkg::EMPTY);
    assign o_tx_valid = (state == cmd_pkg::FULL);
    assign rx_fire    = i_rx_valid && o_rx_ready;

    // only a byte accepted this clock is decoded
    always_comb begin
        cmd = cmd_pkg::CMD_NONE;
        if (rx_fire) begin
            case (i_rx_data)
                cmd_pkg::ASC_RIGHT: cmd = cmd_pkg::CMD_RIGHT;
                cmd_pkg::ASC_LEFT:  cmd = cmd_pkg::CMD_LEFT;
                cmd_pkg::ASC_UP:    cmd = cmd_pkg::CMD_UP;
                cmd_pkg::ASC_DOWN:  cmd = cmd_pkg::CMD_DOWN;
                cmd_pkg::ASC_MODE:  cmd = cmd_pkg::CMD_MODE;
                default:            cmd = cmd_pkg::CMD_NONE;
            endcase
        end
    end

    assign req_right = i_btn_right || (cmd == cmd_pkg::CMD_RIGHT);
    assign req_left  = i_btn_left  || (cmd == cmd_pkg::CMD_LEFT);
    assign req_up    = i_btn_up    || (cmd == cmd_pkg::CMD_UP);
    assign req_down  = i_btn_down  || (cmd == cmd_pkg::CMD_DOWN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= cmd_pkg::EMPTY;
            o_right <= 1'b0;
            o_left  <= 1'b0;
            o_up    <= 1'b0;
            o_down  <= 1'b0;
            o_mode  <= 1'b0;
        end else begin
            if (rx_fire) begin
                state <= cmd_pkg::FULL;
            end else if (o_tx_valid && i_tx_ready) begin
                state <= cmd_pkg::EMPTY;
            end
            // right beats left beats up beats down; mode stands apart
            o_right <= req_right;
            o_left  <= req_left && !req_right;
            o_up    <= req_up && !req_right && !req_left;
            o_down  <= req_down && !req_right && !req_left && !req_up;
            o_mode  <= (cmd == cmd_pkg::CMD_MODE);
        end
    end

    // echo byte
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            o_tx_data <= i_rx_data;
        end
    end

endmodule

/* source/uart_cmd_top.sv */
`timescale 1ns/10ps

module uart_cmd_top (
    input  logic clk,
    input  logic rst,
    input  logic i_rx,
    input  logic i_btn_right,
    input  logic i_btn_left,
    input  logic i_btn_up,
    input  logic i_btn_down,
    output logic o_tx,
    output logic o_right,
    output logic o_left,
    output logic o_up,
    output logic o_down,
    output logic o_mode
);

    logic            tick;
    uart_pkg::byte_t rx_data;
    logic            rx_valid;
    logic            rx_ready;
    uart_pkg::byte_t tx_data;
    logic            tx_valid;
    logic            tx_ready;

    // 16x bit-rate tick
    baud_gen u_baud_gen (
        .clk   (clk),
        .rst   (rst),
        .o_tick(tick)
    );

    uart_receiver u_uart_receiver (
        .clk       (clk),
        .rst       (rst),
        .i_tick    (tick),
        .i_rx      (i_rx),
        .o_rx_data (rx_data),
        .o_rx_valid(rx_valid),
        .i_rx_ready(rx_ready)
    );

    // decode, button merge and echo
    cmd_ctrl u_cmd_ctrl (
        .clk        (clk),
        .rst        (rst),
        .i_rx_data  (rx_data),
        .i_rx_valid (rx_valid),
        .o_rx_ready (rx_ready),
        .o_tx_data  (tx_data),
        .o_tx_valid (tx_valid),
        .i_tx_ready (tx_ready),
        .i_btn_right(i_btn_right),
        .i_btn_left (i_btn_left),
        .i_btn_up   (i_btn_up),
        .i_btn_down (i_btn_down),
        .o_right    (o_right),
        .o_left     (o_left),
        .o_up       (o_up),
        .o_down     (o_down),
        .o_mode     (o_mode)
    );

    uart_transmitter u_uart_transmitter (
        .clk       (clk),
        .rst       (rst),
        .i_tick    (tick),
        .i_tx_data (tx_data),
        .i_tx_valid(tx_valid),
        .o_tx_ready(tx_ready),
        .o_tx      (o_tx)
    );

endmodule

/* tests/tb_tasks.svh */
task automatic compare_byte(input uart_pkg::byte_t got, input uart_pkg::byte_t exp,
                            input string what);
    check_cnt++;
    if (got !== exp) begin
        error_cnt++;
        $display("Error at %0t: %s got %02h, expected %02h", $time, what, got, exp);
    end
endtask

// expected pulse vector follows from the command alone
task automatic compare_pulse(input cmd_pkg::cmd_e exp, input logic r, input logic l,
                             input logic u, input logic d, input logic m);
    logic [4:0] got;
    logic [4:0] want;
    got  = {r, l, u, d, m};
    want = {exp == cmd_pkg::CMD_RIGHT, exp == cmd_pkg::CMD_LEFT, exp == cmd_pkg::CMD_UP,
            exp == cmd_pkg::CMD_DOWN, exp == cmd_pkg::CMD_MODE};
    check_cnt++;
    if (got !== want) begin
        error_cnt++;
        $display("Error at %0t: pulses r,l,u,d,m = %05b, expected %05b for %s",
                 $time, got, want, exp.name());
    end
endtask

task automatic compare_line(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
        error_cnt++;
        $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic send_bit(input logic v);
    @(posedge clk);
    rx <= v;
    repeat (BIT_CLKS - 1) @(posedge clk);
endtask

// 8N1 frame sent lsb first
task automatic send_byte(input uart_pkg::byte_t b);
    int i;
    send_bit(1'b0);
    for (i = 0; i < uart_pkg::DATA_BITS; i++) begin
        send_bit(b[i]);
    end
    send_bit(1'b1);
endtask

// waits for the start edge on o_tx, then samples each bit at its middle
task automatic recv_byte(output uart_pkg::byte_t b);
    uart_pkg::byte_t data;
    int              i;
    @(negedge clk);
    while (tx !== 1'b0) begin
        @(negedge clk);
    end
    repeat (BIT_CLKS / 2) @(negedge clk);
    if (tx !== 1'b0) begin
        error_cnt++;
        $display("Start bit on o_tx went high before its middle at %0t", $time);
    end
    for (i = 0; i < uart_pkg::DATA_BITS; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        data[i] = tx;
    end
    repeat (BIT_CLKS) @(negedge clk);
    if (tx !== 1'b1) begin
        error_cnt++;
        $display("Stop bit on o_tx was low at %0t", $time);
    end
    b = data;
endtask

task automatic watch_pulses(input cmd_pkg::cmd_e exp);
    int seen;
    seen = 0;
    while (!echo_done) begin
        @(negedge clk);
        if (pulse_right || pulse_left || pulse_up || pulse_down || pulse_mode) begin
            seen++;
            compare_pulse(exp, pulse_right, pulse_left, pulse_up, pulse_down, pulse_mode);
        end
    end
    if (exp != cmd_pkg::CMD_NONE && seen != 1) begin
        error_cnt++;
        $display("Command %s gave %0d pulse clocks instead of one", exp.name(), seen);
    end
endtask

task automatic check_command(input uart_pkg::byte_t b, input cmd_pkg::cmd_e exp);
    uart_pkg::byte_t got;
    echo_done = 1'b0;
    fork
        send_byte(b);
        begin
            recv_byte(got);
            compare_byte(got, b, "command echo");
            echo_done = 1'b1;
        end
        watch_pulses(exp);
    join
endtask

task automatic check_reset_state;
    @(negedge clk);
    compare_line(tx, 1'b1, "o_tx after reset");
    compare_pulse(cmd_pkg::CMD_NONE, pulse_right, pulse_left, pulse_up, pulse_down,
                  pulse_mode);
endtask

task automatic echo_random_bytes(input int n);
    uart_pkg::byte_t b;
    uart_pkg::byte_t got;
    int              i;
    for (i = 0; i < n; i++) begin
        b = uart_pkg::byte_t'($urandom);
        fork
            send_byte(b);
            begin
                recv_byte(got);
                compare_byte(got, b, "echo");
            end
        join
    end
endtask

task automatic decode_commands;
    check_command(cmd_pkg::ASC_RIGHT, cmd_pkg::CMD_RIGHT);
    check_command(cmd_pkg::ASC_LEFT, cmd_pkg::CMD_LEFT);
    check_command(cmd_pkg::ASC_UP, cmd_pkg::CMD_UP);
    check_command(cmd_pkg::ASC_DOWN, cmd_pkg::CMD_DOWN);
    check_command(cmd_pkg::ASC_MODE, cmd_pkg::CMD_MODE);
    // digit and unknown letter are echo only
    check_command(8'h30, cmd_pkg::CMD_NONE);
    check_command(8'h78, cmd_pkg::CMD_NONE);
endtask

// pulse must follow the buttons and stay up while they are held
task automatic hold_and_check(input cmd_pkg::cmd_e exp);
    repeat (2) @(negedge clk);
    repeat (4) begin
        @(negedge clk);
        compare_pulse(exp, pulse_right, pulse_left, pulse_up, pulse_down, pulse_mode);
    end
endtask

task automatic walk_button_priority;
    @(posedge clk);
    btn_right <= 1'b1;
    btn_left  <= 1'b1;
    btn_up    <= 1'b1;
    btn_down  <= 1'b1;
    hold_and_check(cmd_pkg::CMD_RIGHT);
    @(posedge clk);
    btn_right <= 1'b0;
    hold_and_check(cmd_pkg::CMD_LEFT);
    @(posedge clk);
    btn_left <= 1'b0;
    hold_and_check(cmd_pkg::CMD_UP);
    @(posedge clk);
    btn_up <= 1'b0;
    hold_and_check(cmd_pkg::CMD_DOWN);
    @(posedge clk);
    btn_down <= 1'b0;
    hold_and_check(cmd_pkg::CMD_NONE);
endtask

task automatic stream_back_to_back(input int n);
    uart_pkg::byte_t sent[$];
    uart_pkg::byte_t got;
    int              i;
    int              j;
    int              k;
    for (i = 0; i < n; i++) begin
        sent.push_back(uart_pkg::byte_t'($urandom));
    end
    fork
        begin
            for (j = 0; j < n; j++) begin
                send_byte(sent[j]);
            end
        end
        begin
            for (k = 0; k < n; k++) begin
                recv_byte(got);
                compare_byte(got, sent[k], "back-to-back echo");
            end
        end
    join
endtask

/* tests/tb_uart_cmd_top.sv */
`timescale 1ns/10ps

module tb_uart_cmd_top;

    localparam int BIT_CLKS   = uart_pkg::OVERSAMPLE * uart_pkg::TICK_DIV;
    localparam int FRAME_CLKS = 10 * BIT_CLKS;
    // about 40 frames of serial traffic plus margin
    localparam int MAX_CYCLES = 40 * FRAME_CLKS + 50_000;

    logic clk;
    logic rst;
    logic rx;
    logic btn_right;
    logic btn_left;
    logic btn_up;
    logic btn_down;
    logic tx;
    logic pulse_right;
    logic pulse_left;
    logic pulse_up;
    logic pulse_down;
    logic pulse_mode;

    int   error_cnt;
    int   check_cnt;
    int   cycle_cnt = 0;
    logic echo_done;

    uart_cmd_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .i_rx       (rx),
        .i_btn_right(btn_right),
        .i_btn_left (btn_left),
        .i_btn_up   (btn_up),
        .i_btn_down (btn_down),
        .o_tx       (tx),
        .o_right    (pulse_right),
        .o_left     (pulse_left),
        .o_up       (pulse_up),
        .o_down     (pulse_down),
        .o_mode     (pulse_mode)
    );

    `include "tb_tasks.svh"

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(81));
        clk       = 1'b0;
        rst       = 1'b1;
        rx        = 1'b1;
        btn_right = 1'b0;
        btn_left  = 1'b0;
        btn_up    = 1'b0;
        btn_down  = 1'b0;
        echo_done = 1'b0;
        error_cnt = 0;
        check_cnt = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        check_reset_state();
        echo_random_bytes(8);
        decode_commands();
        walk_button_priority();
        stream_back_to_back(6);

        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* uart_cmd_top.f */
+incdir+tests
source/uart_pkg.sv
source/cmd_pkg.sv
source/baud_gen.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/cmd_ctrl.sv
source/uart_cmd_top.sv
tests/tb_uart_cmd_top.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then scan the log for the failure line
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_uart_cmd_top -f uart_cmd_top.f -o tb_uart_cmd_top \
    && ./obj_dir/tb_uart_cmd_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation clean"; exit 0; }
